//--- Makefile
TOP := tb_lcd

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing -GCLK_FREQ=2 -f vlog.f --top-module $(TOP) -Mdir obj_dir -o sim_lcd
	./obj_dir/sim_lcd > sim.log 2>&1; cat sim.log
	grep -q "^ALL TESTS PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- hw/lcd_cmd_fifo.sv
`timescale 1ns/1ns
`include "lcd_settings.svh"

module lcd_cmd_fifo #(
	parameter int DEPTH = `LCD_FIFO_DEPTH,
	parameter int W     = lcd_cmd_pkg::CMD_W
) (
	input  logic         clk,
	input  logic         arst_n,
	input  logic         wr,
	input  logic [W-1:0] wdata,
	input  logic         rd,
	output logic [W-1:0] rdata,
	output logic         empty,
	output logic         full
);

	localparam int AW = $clog2(DEPTH);

	logic [W-1:0] mem [DEPTH];
	logic [AW:0]  wr_ptr;     // extra bit tells wrap parity
	logic [AW:0]  rd_ptr;
	logic         do_wr;
	logic         do_rd;

	assign do_wr = wr && !full;    // drop on full
	assign do_rd = rd && !empty;

	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	assign rdata = mem[rd_ptr[AW-1:0]];    // head word, no read latency

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr[AW-1:0]] <= wdata;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

endmodule

//--- hw/lcd_cmd_pkg.sv
package lcd_cmd_pkg;

	localparam int MODE_W = 7;     // display-mode word
	localparam int CMD_W  = 10;    // {rs, rw, data}

	// display-mode word bit positions
	localparam int LINES_BIT  = 6;
	localparam int FONT_BIT   = 5;
	localparam int DISP_BIT   = 4;
	localparam int CURSOR_BIT = 3;
	localparam int BLINK_BIT  = 2;
	localparam int ID_BIT     = 1;
	localparam int SHIFT_BIT  = 0;

	// two lines, 5x8, display on, cursor off, blink off, increment, no shift
	localparam logic [MODE_W-1:0] MODE_DEFAULT = 7'b1_0_1_0_0_1_0;

	// command word fields
	localparam int RS_BIT   = 9;
	localparam int RW_BIT   = 8;
	localparam int DATA_LSB = 0;

	// instruction opcode prefixes
	localparam logic [3:0] FUNC_SET   = 4'b0011;    // 8-bit bus
	localparam logic [4:0] DISP_CTRL  = 5'b00001;
	localparam logic [7:0] CLEAR      = 8'b00000001;
	localparam logic [5:0] ENTRY_MODE = 6'b000001;

endpackage

//--- hw/lcd_config_regs.sv
`timescale 1ns/1ns

module lcd_config_regs (
	input  logic                             clk,
	input  logic                             arst_n,
	input  logic                             cfg_wr,
	input  logic [lcd_cmd_pkg::MODE_W-1:0]   cfg_wdata,
	input  logic                             cfg_reinit,
	output logic [lcd_cmd_pkg::MODE_W-1:0]   mode,
	output logic                             reinit_pulse
);

	logic reinit_q;    // previous strobe level

	// display-mode register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mode <= lcd_cmd_pkg::MODE_DEFAULT;
		end else if (cfg_wr) begin
			mode <= cfg_wdata;
		end
	end

	// The restart pulse leaves one cycle after the strobe, so a mode write in
	// the same cycle is already visible when the controller begins init.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			reinit_q     <= 1'b0;
			reinit_pulse <= 1'b0;
		end else begin
			reinit_q     <= cfg_reinit;
			reinit_pulse <= cfg_reinit && !reinit_q;    // rising edge only
		end
	end

endmodule

//--- hw/lcd_controller.sv
`timescale 1ns/1ns
`include "lcd_settings.svh"

module lcd_controller #(
	parameter int CLK_FREQ = `CLK_FREQ
) (
	input  logic                             clk,
	input  logic                             arst_n,
	input  logic [lcd_cmd_pkg::MODE_W-1:0]   mode,
	input  logic                             reinit,
	input  logic [lcd_cmd_pkg::CMD_W-1:0]    fifo_word,
	input  logic                             fifo_empty,
	output logic                             pop,
	output logic                             e,
	output logic                             rs,
	output logic                             rw,
	output logic [7:0]                       lcd_data,
	output logic                             busy,
	output logic                             ready
);

	localparam int CW = `LCD_CNT_W;

	// step edges in clock cycles
	localparam logic [CW-1:0] T_POWERUP  = CW'(lcd_ctrl_pkg::POWERUP_US * CLK_FREQ - 1);
	localparam logic [CW-1:0] T_FS_OFF   = CW'(lcd_ctrl_pkg::FS_OFF_US * CLK_FREQ);
	localparam logic [CW-1:0] T_DC_ON    = CW'(lcd_ctrl_pkg::DC_ON_US * CLK_FREQ);
	localparam logic [CW-1:0] T_DC_OFF   = CW'(lcd_ctrl_pkg::DC_OFF_US * CLK_FREQ);
	localparam logic [CW-1:0] T_CLR_ON   = CW'(lcd_ctrl_pkg::CLR_ON_US * CLK_FREQ);
	localparam logic [CW-1:0] T_CLR_OFF  = CW'(lcd_ctrl_pkg::CLR_OFF_US * CLK_FREQ);
	localparam logic [CW-1:0] T_EM_ON    = CW'(lcd_ctrl_pkg::EM_ON_US * CLK_FREQ);
	localparam logic [CW-1:0] T_EM_OFF   = CW'(lcd_ctrl_pkg::EM_OFF_US * CLK_FREQ);
	localparam logic [CW-1:0] T_INIT_END = CW'(lcd_ctrl_pkg::INIT_END_US * CLK_FREQ - 1);
	// outputs are registered, so write edges fire one count early
	localparam logic [CW-1:0] T_E_ON     = CW'(lcd_ctrl_pkg::E_ON_US * CLK_FREQ - 1);
	localparam logic [CW-1:0] T_E_OFF    = CW'(lcd_ctrl_pkg::E_OFF_US * CLK_FREQ - 1);
	localparam logic [CW-1:0] T_WR_END   = CW'(lcd_ctrl_pkg::WRITE_US * CLK_FREQ - 1);

	logic [1:0]    phase;
	logic [CW-1:0] cnt;       // shared by all timed phases
	logic [7:0]    fs_byte;
	logic [7:0]    dc_byte;
	logic [7:0]    em_byte;

	assign fs_byte = {lcd_cmd_pkg::FUNC_SET, mode[lcd_cmd_pkg::LINES_BIT],
		mode[lcd_cmd_pkg::FONT_BIT], 2'b00};
	assign dc_byte = {lcd_cmd_pkg::DISP_CTRL, mode[lcd_cmd_pkg::DISP_BIT],
		mode[lcd_cmd_pkg::CURSOR_BIT], mode[lcd_cmd_pkg::BLINK_BIT]};
	assign em_byte = {lcd_cmd_pkg::ENTRY_MODE, mode[lcd_cmd_pkg::ID_BIT],
		mode[lcd_cmd_pkg::SHIFT_BIT]};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			phase    <= lcd_ctrl_pkg::PH_POWERUP;
			cnt      <= '0;
			pop      <= 1'b0;
			e        <= 1'b0;
			rs       <= 1'b0;
			rw       <= 1'b0;
			lcd_data <= '0;
			busy     <= 1'b1;
			ready    <= 1'b0;
		end else if (reinit) begin    // restart at function set, no power-up wait
			phase    <= lcd_ctrl_pkg::PH_INIT;
			cnt      <= '0;
			pop      <= 1'b0;
			e        <= 1'b0;
			rs       <= 1'b0;
			rw       <= 1'b0;
			lcd_data <= '0;
			busy     <= 1'b1;
			ready    <= 1'b0;
		end else begin
			case (phase)
				lcd_ctrl_pkg::PH_POWERUP: begin
					if (cnt == T_POWERUP) begin
						phase <= lcd_ctrl_pkg::PH_INIT;
						cnt   <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				lcd_ctrl_pkg::PH_INIT: begin
					cnt <= cnt + 1'b1;
					// each byte is taken from mode when its pulse starts
					if (cnt == '0) begin
						e        <= 1'b1;
						lcd_data <= fs_byte;
					end else if (cnt == T_DC_ON) begin
						e        <= 1'b1;
						lcd_data <= dc_byte;
					end else if (cnt == T_CLR_ON) begin
						e        <= 1'b1;
						lcd_data <= lcd_cmd_pkg::CLEAR;
					end else if (cnt == T_EM_ON) begin
						e        <= 1'b1;
						lcd_data <= em_byte;
					end else if (cnt == T_FS_OFF || cnt == T_DC_OFF ||
							cnt == T_CLR_OFF || cnt == T_EM_OFF) begin
						e        <= 1'b0;
						lcd_data <= '0;
					end else if (cnt == T_INIT_END) begin
						phase <= lcd_ctrl_pkg::PH_IDLE;
						cnt   <= '0;
						busy  <= 1'b0;
						ready <= 1'b1;
					end
				end
				lcd_ctrl_pkg::PH_IDLE: begin
					if (pop) begin    // head word still valid this cycle
						pop      <= 1'b0;
						rs       <= fifo_word[lcd_cmd_pkg::RS_BIT];
						rw       <= fifo_word[lcd_cmd_pkg::RW_BIT];
						lcd_data <= fifo_word[lcd_cmd_pkg::DATA_LSB +: 8];
						busy     <= 1'b1;
						phase    <= lcd_ctrl_pkg::PH_WRITE;
						cnt      <= '0;
					end else if (!fifo_empty) begin
						pop <= 1'b1;
					end
				end
				default: begin    // write window
					cnt <= cnt + 1'b1;
					if (cnt == T_E_ON) begin
						e <= 1'b1;
					end else if (cnt == T_E_OFF) begin
						e <= 1'b0;
					end else if (cnt == T_WR_END) begin
						phase    <= lcd_ctrl_pkg::PH_IDLE;
						cnt      <= '0;
						rs       <= 1'b0;
						rw       <= 1'b0;
						lcd_data <= '0;
						busy     <= 1'b0;
					end
				end
			endcase
		end
	end

endmodule

//--- hw/lcd_ctrl_pkg.sv
package lcd_ctrl_pkg;

	// controller phases
	localparam logic [1:0] PH_POWERUP = 2'd0;
	localparam logic [1:0] PH_INIT    = 2'd1;
	localparam logic [1:0] PH_IDLE    = 2'd2;
	localparam logic [1:0] PH_WRITE   = 2'd3;

	localparam int POWERUP_US = 500;

	// init step edges, microseconds from the start of init
	localparam int FS_OFF_US   = 10;     // function set pulse ends
	localparam int DC_ON_US    = 60;
	localparam int DC_OFF_US   = 70;
	localparam int CLR_ON_US   = 120;
	localparam int CLR_OFF_US  = 130;
	localparam int EM_ON_US    = 330;    // clear needs the long wait
	localparam int EM_OFF_US   = 340;
	localparam int INIT_END_US = 440;

	// data write window
	localparam int WRITE_US  = 50;
	localparam int E_ON_US   = 1;
	localparam int E_OFF_US  = 14;

endpackage

//--- hw/lcd_settings.svh
`ifndef LCD_SETTINGS_SVH
`define LCD_SETTINGS_SVH

// default clock cycles per microsecond
`define CLK_FREQ 50

// command word entries as a power of two
`define LCD_FIFO_DEPTH 8

// timing counter width covering 500 * CLK_FREQ
`define LCD_CNT_W 18

`endif

//--- hw/lcd_subsystem.sv
`timescale 1ns/1ns
`include "lcd_settings.svh"

module lcd_subsystem #(
	parameter int CLK_FREQ = `CLK_FREQ
) (
	input  logic                             clk,
	input  logic                             arst_n,
	input  logic                             cfg_wr,
	input  logic [lcd_cmd_pkg::MODE_W-1:0]   cfg_wdata,
	input  logic                             cfg_reinit,
	input  logic                             cmd_wr,
	input  logic [lcd_cmd_pkg::CMD_W-1:0]    cmd_word,
	output logic                             cmd_full,
	output logic                             ready,
	output logic                             busy,
	output logic                             e,
	output logic                             rs,
	output logic                             rw,
	output logic [7:0]                       lcd_data
);

	logic [lcd_cmd_pkg::MODE_W-1:0] mode;
	logic                           reinit_pulse;
	logic [lcd_cmd_pkg::CMD_W-1:0]  rd_word;
	logic                           empty;
	logic                           pop;

	lcd_config_regs u_regs (
		.clk          (clk),
		.arst_n       (arst_n),
		.cfg_wr       (cfg_wr),
		.cfg_wdata    (cfg_wdata),
		.cfg_reinit   (cfg_reinit),
		.mode         (mode),
		.reinit_pulse (reinit_pulse)
	);

	lcd_cmd_fifo u_fifo (
		.clk    (clk),
		.arst_n (arst_n),
		.wr     (cmd_wr),
		.wdata  (cmd_word),
		.rd     (pop),
		.rdata  (rd_word),
		.empty  (empty),
		.full   (cmd_full)
	);

	lcd_controller #(
		.CLK_FREQ (CLK_FREQ)
	) u_ctrl (
		.clk        (clk),
		.arst_n     (arst_n),
		.mode       (mode),
		.reinit     (reinit_pulse),
		.fifo_word  (rd_word),
		.fifo_empty (empty),
		.pop        (pop),
		.e          (e),
		.rs         (rs),
		.rw         (rw),
		.lcd_data   (lcd_data),
		.busy       (busy),
		.ready      (ready)
	);

endmodule

//--- tb/lcd_checker.sv
`timescale 1ns/1ns
`include "lcd_settings.svh"

module lcd_checker #(
	parameter int CLK_FREQ = `CLK_FREQ,
	parameter int DEPTH    = `LCD_FIFO_DEPTH
) (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       cfg_wr,
	input  logic [6:0] cfg_wdata,
	input  logic       cfg_reinit,
	input  logic       cmd_wr,
	input  logic [9:0] cmd_word,
	input  logic       cmd_full,
	input  logic       ready,
	input  logic       busy,
	input  logic       e,
	input  logic       rs,
	input  logic       rw,
	input  logic [7:0] lcd_data,
	input  logic       end_of_test,
	output int         errors,
	output int         dropped
);

	logic [9:0] pending[$];    // accepted words not yet on the bus
	logic [6:0] mode_model;
	logic [9:0] bus_exp;
	int         fifo_cnt;      // FIFO occupancy after the last edge
	int         step;
	int         width;
	int         width_exp;
	int         cycle;
	logic       in_init;
	logic       first_pulse;
	logic       idle_seen;
	logic       ended;
	logic       e_q;
	logic       busy_q;
	logic       ready_q;

	// steps 0..3 are the HD44780 init instructions and later steps a data write
	function automatic logic [9:0] expected_bus(input int s, input logic [6:0] m,
			input logic [9:0] word);
		case (s)
			0: return {2'b00, 4'b0011, m[lcd_cmd_pkg::LINES_BIT],
				m[lcd_cmd_pkg::FONT_BIT], 2'b00};
			1: return {2'b00, 5'b00001, m[lcd_cmd_pkg::DISP_BIT],
				m[lcd_cmd_pkg::CURSOR_BIT], m[lcd_cmd_pkg::BLINK_BIT]};
			2: return 10'h001;
			3: return {2'b00, 6'b000001, m[lcd_cmd_pkg::ID_BIT], m[lcd_cmd_pkg::SHIFT_BIT]};
			default: return word;
		endcase
	endfunction

	task automatic compare_value(input string name, input logic [31:0] exp_v,
			input logic [31:0] act_v);
		if (exp_v !== act_v) begin
			errors++;
			$display("mismatch %s: expected 0x%0h, actual 0x%0h", name, exp_v, act_v);
		end
	endtask

	task automatic report_error(input string what);
		errors++;
		$display("error at %0t ns: %s", $time, what);
	endtask

	// samples pre-edge values of inputs driven on the falling edge
	always @(posedge clk) begin
		if (!arst_n) begin
			pending.delete();
			mode_model = '0;
			mode_model[lcd_cmd_pkg::LINES_BIT] = 1'b1;
			mode_model[lcd_cmd_pkg::DISP_BIT]  = 1'b1;
			mode_model[lcd_cmd_pkg::ID_BIT]    = 1'b1;
			bus_exp = '0;
			fifo_cnt = 0;
			step = 0;
			width = 0;
			width_exp = 0;
			cycle = 0;
			in_init = 1'b1;
			first_pulse = 1'b0;
			idle_seen = 1'b0;
			ended = 1'b0;
			e_q = 1'b0;
			busy_q = 1'b1;
			ready_q = 1'b0;
			errors = 0;
			dropped = 0;
		end else begin
			if (cycle == 0) begin    // first sample after reset release
				compare_value("e", 32'(1'b0), 32'(e));
				compare_value("busy", 32'(1'b1), 32'(busy));
				compare_value("ready", 32'(1'b0), 32'(ready));
			end
			// busy rising while ready holds means a pop at the previous edge
			if (busy && !busy_q && ready && ready_q) begin
				fifo_cnt--;
			end
			compare_value("cmd_full", 32'(fifo_cnt == DEPTH), 32'(cmd_full));
			if (cmd_wr) begin
				if (fifo_cnt < DEPTH) begin
					pending.push_back(cmd_word);
					fifo_cnt++;
				end else begin
					dropped++;    // dropped by the full FIFO
				end
			end
			if (cfg_wr) begin
				mode_model = cfg_wdata;
			end
			if (cfg_reinit) begin
				in_init = 1'b1;
				step = 0;
			end
			if (!busy) begin
				idle_seen = 1'b1;
			end
			if (e && !e_q) begin
				if (in_init) begin
					if (!first_pulse && cycle < 500 * CLK_FREQ) begin
						report_error("first enable pulse came before the power-up wait ended");
					end
					if (ready) begin
						report_error("ready was high during init");
					end
					if (step > 3) begin
						report_error("more than four enable pulses during init");
					end
					bus_exp = expected_bus(step, mode_model, 10'h000);
					width_exp = 10 * CLK_FREQ;
					step++;
				end else if (pending.size() == 0) begin
					report_error("enable pulse without a queued command word");
					bus_exp = '0;
					width_exp = 13 * CLK_FREQ;
				end else begin
					if (!idle_seen) begin
						report_error("busy did not fall between two writes");
					end
					bus_exp = expected_bus(4, mode_model, pending.pop_front());
					width_exp = 13 * CLK_FREQ;
				end
				first_pulse = 1'b1;
				idle_seen = 1'b0;
				width = 0;
			end
			if (e) begin
				width++;
				compare_value("{rs,rw,lcd_data}", 32'(bus_exp), 32'({rs, rw, lcd_data}));
			end else if (e_q) begin
				compare_value("e pulse width", width_exp, width);
			end
			if (ready && !ready_q) begin
				if (!in_init || step != 4) begin
					report_error("ready rose before the four init pulses were seen");
				end
				in_init = 1'b0;
			end
			if (end_of_test && !ended) begin
				ended = 1'b1;
				if (pending.size() != 0) begin
					report_error($sformatf("%0d command words never reached the bus",
						pending.size()));
				end
				if (dropped == 0) begin
					report_error("no command word was dropped by the full FIFO");
				end
				if (in_init) begin
					report_error("the last init sequence did not complete");
				end
			end
			e_q = e;
			busy_q = busy;
			ready_q = ready;
			cycle++;
		end
	end

endmodule

//--- tb/tb_lcd.sv
`timescale 1ns/1ns
`include "lcd_settings.svh"

module tb_lcd;

	parameter int CLK_FREQ = `CLK_FREQ;
	localparam int DEPTH = `LCD_FIFO_DEPTH;

	logic        clk;
	logic        arst_n;
	logic        cfg_wr;
	logic [6:0]  cfg_wdata;
	logic        cfg_reinit;
	logic        cmd_wr;
	logic [9:0]  cmd_word;
	logic        cmd_full;
	logic        ready;
	logic        busy;
	logic        e;
	logic        rs;
	logic        rw;
	logic [7:0]  lcd_data;
	logic        end_of_test;
	int          chk_errors;
	int          dropped;
	int          tb_errors;
	logic [31:0] rng;

	always #20 clk = ~clk;    // 40 ns period

	lcd_subsystem #(.CLK_FREQ(CLK_FREQ)) uut (
		.clk(clk), .arst_n(arst_n), .cfg_wr(cfg_wr), .cfg_wdata(cfg_wdata),
		.cfg_reinit(cfg_reinit), .cmd_wr(cmd_wr), .cmd_word(cmd_word),
		.cmd_full(cmd_full), .ready(ready), .busy(busy), .e(e), .rs(rs), .rw(rw),
		.lcd_data(lcd_data)
	);

	lcd_checker #(.CLK_FREQ(CLK_FREQ), .DEPTH(DEPTH)) chk (
		.clk(clk), .arst_n(arst_n), .cfg_wr(cfg_wr), .cfg_wdata(cfg_wdata),
		.cfg_reinit(cfg_reinit), .cmd_wr(cmd_wr), .cmd_word(cmd_word),
		.cmd_full(cmd_full), .ready(ready), .busy(busy), .e(e), .rs(rs), .rw(rw),
		.lcd_data(lcd_data), .end_of_test(end_of_test), .errors(chk_errors),
		.dropped(dropped)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// back-to-back random command words, one per cycle
	task automatic push_random(input int n);
		for (int i = 0; i < n; i++) begin
			@(negedge clk);
			rng = xorshift32(rng);
			cmd_wr = 1'b1;
			cmd_word = rng[9:0];
		end
		@(negedge clk);
		cmd_wr = 1'b0;
	endtask

	task automatic wait_level(input string name, input logic level, input int limit);
		int n;
		n = 0;
		while (((name == "ready") ? ready : busy) != level) begin
			if (n == limit) begin
				tb_errors++;
				$display("timeout: %s did not reach %0b within %0d cycles", name, level, limit);
				return;
			end
			@(negedge clk);
			n++;
		end
	endtask

	// one busy high then low per write window
	task automatic drain_writes(input int n);
		for (int i = 0; i < n; i++) begin
			wait_level("busy", 1'b1, 60 * CLK_FREQ);
			wait_level("busy", 1'b0, 60 * CLK_FREQ);
		end
	endtask

	initial begin
		clk = 1'b0;
		arst_n = 1'b0;
		cfg_wr = 1'b0;
		cfg_wdata = '0;
		cfg_reinit = 1'b0;
		cmd_wr = 1'b0;
		cmd_word = '0;
		end_of_test = 1'b0;
		tb_errors = 0;
		rng = 32'hca95_79d2;
		repeat (10) @(negedge clk);
		arst_n = 1'b1;
		wait_level("ready", 1'b1, (500 + 440) * CLK_FREQ + 20);
		for (int i = 0; i < 5; i++) begin    // spaced single pushes
			push_random(1);
			repeat (3) @(negedge clk);
		end
		drain_writes(5);
		push_random(1);    // keeps the controller busy during the burst
		wait_level("busy", 1'b1, 20);
		push_random(DEPTH + 1);    // last word meets a full FIFO
		drain_writes(DEPTH + 1);
		@(negedge clk);
		rng = xorshift32(rng);
		cfg_wr = 1'b1;
		cfg_wdata = rng[6:0];
		cfg_reinit = 1'b1;
		@(negedge clk);
		cfg_wr = 1'b0;
		cfg_reinit = 1'b0;
		wait_level("ready", 1'b0, 10);
		push_random(3);    // queued while init runs
		wait_level("ready", 1'b1, 440 * CLK_FREQ + 20);
		drain_writes(3);
		@(negedge clk);
		end_of_test = 1'b1;
		repeat (2) @(negedge clk);
		$display("checker errors: %0d, testbench errors: %0d, dropped words: %0d",
			chk_errors, tb_errors, dropped);
		if (chk_errors == 0 && tb_errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- vlog.f
+incdir+hw
hw/lcd_cmd_pkg.sv
hw/lcd_ctrl_pkg.sv
hw/lcd_config_regs.sv
hw/lcd_cmd_fifo.sv
hw/lcd_controller.sv
hw/lcd_subsystem.sv
tb/lcd_checker.sv
tb/tb_lcd.sv
